// ==== design/board_status.sv ====
// board status outputs, toggled vsync marker for the host mcu and the dimmed power led
`timescale 1ns/1ps
`default_nettype none

module board_status (
	input  logic clk,
	input  logic reset,
	input  logic clk7_en_i,
	input  logic vsync_n_i,   // agnus vertical sync, active low
	input  logic hblank_i,
	input  logic led_n_i,     // power led bit from cia a
	output logic init_b_o,    // toggles once per frame
	output logic pwr_led_o
);

	logic vsync_q;   // previous sample
	logic vsync_fall;

	// ------------------------------
	// vsync marker
	// ------------------------------
	assign vsync_fall = ~vsync_n_i & vsync_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_q  <= 1'b0;   // no false edge right after reset
			init_b_o <= 1'b0;
		end else if (clk7_en_i) begin
			vsync_q <= vsync_n_i;
			if (vsync_fall) begin
				init_b_o <= ~init_b_o;   // mcu syncs osd updates to this
			end
		end
	end

	// led off state is dimmed, lit only during hblank
	assign pwr_led_o = ~(led_n_i & ~hblank_i);

endmodule

`default_nettype wire

// ==== design/config_regs.sv ====
// registers the user configuration words and derives the chipset and memory feature flags
`timescale 1ns/1ps
`default_nettype none

module config_regs
	import minimig_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       clk7_en_i,
	input  logic       minimig_reset_i,   // chipset held in reset
	input  user_cfg_t  user_cfg_i,        // from userio
	input  logic       ovl_i,             // kickstart overlay from cia a
	output user_cfg_t  user_cfg_o,
	output cfg_flags_t cfg_flags_o,
	output logic       ntsc_o             // video standard to agnus and paula
);

	user_cfg_t cfg_q;
	logic      chip_2mb;

	// ------------------------------
	// configuration register
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg_q <= '0;
		end else begin
			cfg_q <= user_cfg_i;   // reloaded every clock
		end
	end

	assign user_cfg_o = cfg_q;

	// ------------------------------
	// derived flags
	// ------------------------------
	assign chip_2mb = &cfg_q.mem.chip_size;

	// fast chip only with aga, no overlay and the full 2MB chip ram
	assign cfg_flags_o.turbochipram = cfg_q.chipset.aga & ~ovl_i
		& cfg_q.cpu.fast_chip & chip_2mb;
	// kickstart shadow, also aga only
	assign cfg_flags_o.turbokick    = ~ovl_i & cfg_q.cpu.fast_kick & cfg_q.chipset.aga;
	assign cfg_flags_o.aga          = cfg_q.chipset.aga;
	assign cfg_flags_o.ecs          = cfg_q.chipset.ecs | cfg_q.chipset.aga;   // aga implies ecs
	assign cfg_flags_o.a1k          = cfg_q.chipset.a1k;
	assign cfg_flags_o.slow_config  = cfg_q.mem.slow_size;

	// ------------------------------
	// video standard latch
	// ------------------------------
	// pal/ntsc from the menu only takes effect across a reset, the
	// beam counters would be confused by a change mid-frame
	always_ff @(posedge clk) begin
		if (reset) begin
			ntsc_o <= NTSC_DEFAULT;
		end else if (clk7_en_i && minimig_reset_i) begin
			ntsc_o <= cfg_q.chipset.ntsc;
		end
	end

endmodule

`default_nettype wire

// ==== design/cpu_read_mux.sv ====
// cpu and custom read bus combining, rtc nibble read, level 7 override and spi data-out
`timescale 1ns/1ps
`default_nettype none

module cpu_read_mux
	import minimig_pkg::*;
(
	input  cpu_addr_t      cpu_addr_i,
	input  logic           cpu_rd_i,
	input  logic           sel_rtc_i,      // rtc space from gary
	input  rtc_t           rtc_i,
	input  cpu_rd_src_t    cpu_src_i,
	input  custom_rd_src_t custom_src_i,
	input  logic           int7_i,         // cartridge nmi
	input  logic [2:0]     ipl_n_i,        // from paula
	input  logic           paula_sdo_i,
	input  logic           user_sdo_i,
	output data_word_t     cpu_data_o,
	output data_word_t     custom_data_o,
	output logic [2:0]     cpu_ipl_n_o,
	output logic           sdo_o
);

	logic [RTC_NIBBLE_W-1:0] rtc_nib_sel;
	logic [RTC_NIBBLE_W+1:0] rtc_bit_lsb;   // nibble index times four
	logic [3:0]              rtc_nib;
	data_word_t              rtc_word;

	// ------------------------------
	// rtc read
	// ------------------------------
	assign rtc_nib_sel = cpu_addr_i[RTC_NIBBLE_MSB:RTC_NIBBLE_LSB];
	assign rtc_bit_lsb = {rtc_nib_sel, 2'b00};
	assign rtc_nib     = rtc_i[rtc_bit_lsb +: 4];

	// must be zero when not selected, it goes into the or below
	assign rtc_word = (sel_rtc_i && cpu_rd_i) ?
		{{(DATA_W - 4){1'b0}}, rtc_nib} : '0;

	// ------------------------------
	// data buses
	// ------------------------------
	// every source drives zero when not addressed
	assign cpu_data_o = cpu_src_i.gary
		| cpu_src_i.cia
		| cpu_src_i.gayle
		| cpu_src_i.cart
		| cpu_src_i.autoconfig
		| rtc_word;

	assign custom_data_o = custom_src_i.agnus
		| custom_src_i.paula
		| custom_src_i.denise
		| custom_src_i.userio;

	// ------------------------------
	// interrupts and spi
	// ------------------------------
	assign cpu_ipl_n_o = int7_i ? IPL_LEVEL7 : ipl_n_i;   // freeze button wins
	assign sdo_o       = paula_sdo_i | user_sdo_i;         // idle low from both

endmodule

`default_nettype wire

// ==== design/minimig_glue.sv ====
// chipset glue top level, connects reset sequencing, config, read combining and board status
`timescale 1ns/1ps
`default_nettype none

module minimig_glue
	import minimig_pkg::*;
(
	input  logic           clk,
	input  logic           reset,
	input  logic           clk7_en_i,

	// reset sequencing
	input  rst_req_t       rst_req_i,
	input  logic           sof_i,
	input  logic           cpu_reset_n_i,
	input  logic           cpu_rst_i,
	output logic           sys_reset_o,
	output logic           rst_out_o,       // chipset reset status
	output logic           cpu_reset_n_o,

	// configuration
	input  user_cfg_t      user_cfg_i,
	input  logic           ovl_i,
	output user_cfg_t      user_cfg_o,
	output cfg_flags_t     cfg_flags_o,
	output logic           ntsc_o,

	// cpu read side
	input  cpu_addr_t      cpu_addr_i,
	input  logic           cpu_rd_i,
	input  logic           sel_rtc_i,
	input  rtc_t           rtc_i,
	input  cpu_rd_src_t    cpu_src_i,
	input  custom_rd_src_t custom_src_i,
	input  logic           int7_i,
	input  logic [2:0]     ipl_n_i,
	input  logic           paula_sdo_i,
	input  logic           user_sdo_i,
	output data_word_t     cpu_data_o,
	output data_word_t     custom_data_o,
	output logic [2:0]     cpu_ipl_n_o,
	output logic           sdo_o,

	// board status
	input  logic           vsync_n_i,
	input  logic           hblank_i,
	input  logic           led_n_i,
	output logic           init_b_o,
	output logic           pwr_led_o
);

	logic minimig_reset;   // sequencer or cpu core reset

	sys_reset_ctrl rst0 (
		.clk             (clk),
		.reset           (reset),
		.clk7_en_i       (clk7_en_i),
		.rst_req_i       (rst_req_i),
		.sof_i           (sof_i),
		.cpu_reset_n_i   (cpu_reset_n_i),
		.cpu_rst_i       (cpu_rst_i),
		.sys_reset_o     (sys_reset_o),
		.minimig_reset_o (minimig_reset),
		.cpu_reset_n_o   (cpu_reset_n_o)
	);

	config_regs cfg0 (
		.clk             (clk),
		.reset           (reset),
		.clk7_en_i       (clk7_en_i),
		.minimig_reset_i (minimig_reset),
		.user_cfg_i      (user_cfg_i),
		.ovl_i           (ovl_i),
		.user_cfg_o      (user_cfg_o),
		.cfg_flags_o     (cfg_flags_o),
		.ntsc_o          (ntsc_o)
	);

	cpu_read_mux rd0 (
		.cpu_addr_i    (cpu_addr_i),
		.cpu_rd_i      (cpu_rd_i),
		.sel_rtc_i     (sel_rtc_i),
		.rtc_i         (rtc_i),
		.cpu_src_i     (cpu_src_i),
		.custom_src_i  (custom_src_i),
		.int7_i        (int7_i),
		.ipl_n_i       (ipl_n_i),
		.paula_sdo_i   (paula_sdo_i),
		.user_sdo_i    (user_sdo_i),
		.cpu_data_o    (cpu_data_o),
		.custom_data_o (custom_data_o),
		.cpu_ipl_n_o   (cpu_ipl_n_o),
		.sdo_o         (sdo_o)
	);

	// status block restarts with the chipset, one edge behind the top reset
	board_status stat0 (
		.clk       (clk),
		.reset     (minimig_reset),
		.clk7_en_i (clk7_en_i),
		.vsync_n_i (vsync_n_i),
		.hblank_i  (hblank_i),
		.led_n_i   (led_n_i),
		.init_b_o  (init_b_o),
		.pwr_led_o (pwr_led_o)
	);

	assign rst_out_o = minimig_reset;

endmodule

`default_nettype wire

// ==== design/minimig_pkg.sv ====
// shared types and constants for the chipset glue, imported by every block that needs them
`default_nettype none

package minimig_pkg;

	// ------------------------------
	// bus widths and constants
	// ------------------------------
	localparam int DATA_W         = 16;   // custom and cpu data bus
	localparam int RTC_NIBBLE_LSB = 2;    // cpu address bits picking the rtc nibble
	localparam int RTC_NIBBLE_MSB = 5;
	localparam int RTC_NIBBLE_W   = RTC_NIBBLE_MSB - RTC_NIBBLE_LSB + 1;
	localparam int RESET_FRAMES   = 2;    // frames counted before reset release
	localparam int RST_CNT_W      = $clog2(RESET_FRAMES + 1);

	localparam logic [2:0] IPL_LEVEL7   = 3'b000;  // active low, all lines asserted
	localparam logic       NTSC_DEFAULT = 1'b0;    // pal after power-up

	typedef logic [DATA_W-1:0] data_word_t;
	typedef logic [23:1]       cpu_addr_t;   // 68k word address
	typedef logic [63:0]       rtc_t;        // sixteen bcd nibbles

	// reset requests, all active high
	typedef struct packed {
		logic kbd_rst;    // ctrl-amiga-amiga
		logic usr_rst;    // menu reset
		logic ext_rst;    // external line
		logic host_rst;   // host mcu
	} rst_req_t;

	// ------------------------------
	// user configuration words
	// ------------------------------
	// msb first, so bit positions match the userio registers
	typedef struct packed {
		logic       hrtmon;      // bit 6
		logic [1:0] fast_size;   // bits 5:4
		logic [1:0] slow_size;   // bits 3:2
		logic [1:0] chip_size;   // bits 1:0, 2'b11 is 2MB chip
	} mem_cfg_t;

	typedef struct packed {
		logic aga;         // bit 4
		logic ecs;
		logic a1k;
		logic ntsc;
		logic cpu_turbo;   // bit 0
	} chipset_cfg_t;

	typedef struct packed {
		logic       fast_kick;   // bit 3
		logic       fast_chip;   // bit 2
		logic [1:0] cpu_type;    // 68000 / 68020 select
	} cpu_cfg_t;

	typedef struct packed {
		mem_cfg_t     mem;
		logic [3:0]   floppy;    // drive count and speed
		chipset_cfg_t chipset;
		logic [2:0]   ide;       // gayle, master, slave enables
		cpu_cfg_t     cpu;
	} user_cfg_t;

	// flags handed to the chips and the memory side
	typedef struct packed {
		logic       turbochipram;
		logic       turbokick;
		logic       aga;
		logic       ecs;
		logic       a1k;
		logic [1:0] slow_config;
	} cfg_flags_t;

	// ------------------------------
	// read sources, or-combined
	// ------------------------------
	typedef struct packed {
		data_word_t gary;
		data_word_t cia;
		data_word_t gayle;
		data_word_t cart;
		data_word_t autoconfig;
	} cpu_rd_src_t;

	typedef struct packed {
		data_word_t agnus;
		data_word_t paula;
		data_word_t denise;
		data_word_t userio;
	} custom_rd_src_t;

	typedef enum logic [1:0] {
		RST_HOLD,    // request active
		RST_COUNT,   // waiting on frames
		RST_RUN      // released
	} rst_state_e;

endpackage

`default_nettype wire

// ==== design/sys_reset_ctrl.sv ====
// reset sequencer, merges reset requests and holds the chipset in reset for a few frames
`timescale 1ns/1ps
`default_nettype none

module sys_reset_ctrl
	import minimig_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     clk7_en_i,         // 7 MHz enable
	input  rst_req_t rst_req_i,
	input  logic     sof_i,             // start of frame from agnus
	input  logic     cpu_reset_n_i,     // reset instruction seen by the cpu core
	input  logic     cpu_rst_i,         // cpu reset from the host
	output logic     sys_reset_o,
	output logic     minimig_reset_o,   // chipset reset
	output logic     cpu_reset_n_o
);

	rst_state_e           state;
	logic [RST_CNT_W-1:0] frame_cnt;
	logic [RST_CNT_W-1:0] frame_cnt_nxt;
	logic                 req_any;

	assign req_any       = |rst_req_i;           // any source holds us
	assign frame_cnt_nxt = frame_cnt + 1'b1;

	// ------------------------------
	// state and frame counter
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset || req_any) begin
			state       <= RST_HOLD;
			frame_cnt   <= '0;
			sys_reset_o <= 1'b1;
		end else if (clk7_en_i) begin
			case (state)
				RST_HOLD: begin
					state     <= RST_COUNT;   // requests gone, start counting
					frame_cnt <= '0;
				end
				RST_COUNT: begin
					if (sof_i) begin
						frame_cnt <= frame_cnt_nxt;
						if (frame_cnt_nxt == RST_CNT_W'(RESET_FRAMES)) begin
							state       <= RST_RUN;
							sys_reset_o <= 1'b0;   // release on this edge
						end
					end
				end
				RST_RUN: begin
					sys_reset_o <= 1'b0;
				end
				default: begin
					state       <= RST_HOLD;    // illegal encoding
					sys_reset_o <= 1'b1;
				end
			endcase
		end
	end

	// ------------------------------
	// reset outputs
	// ------------------------------
	// both the core and the sequencer can hold the chipset
	assign minimig_reset_o = sys_reset_o | ~cpu_reset_n_i;
	assign cpu_reset_n_o   = ~(sys_reset_o | cpu_rst_i);   // 68k reset line

endmodule

`default_nettype wire

// ==== filelist.f ====
design/minimig_pkg.sv
design/sys_reset_ctrl.sv
design/config_regs.sv
design/cpu_read_mux.sv
design/board_status.sv
design/minimig_glue.sv
sim/tb_clock_gen.sv
sim/tb_minimig_glue.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the glue testbench with Verilator, pass is decided from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_minimig_glue -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "Simulation completed successfully" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// ==== sim/tb_clock_gen.sv ====
// testbench clock and power-on reset source, instantiated by the glue testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	// 4 ns period
	initial clk = 1'b0;
	always #2 clk = ~clk;

	// reset held high for four rising edges
	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== sim/tb_minimig_glue.sv ====
// table-driven testbench for the chipset glue top level and the top module of the simulation build
`timescale 1ns/1ps
`default_nettype none

module tb_minimig_glue
	import minimig_pkg::*;
;

	localparam logic [2:0] K_CONFIG = 3'd0;
	localparam logic [2:0] K_READ   = 3'd1;
	localparam logic [2:0] K_RESET  = 3'd2;
	localparam logic [2:0] K_NTSC   = 3'd3;
	localparam logic [2:0] K_VSYNC  = 3'd4;
	localparam int         NROWS    = 20;

	// one test case
	// ctl holds {sel_rtc, cpu_rd, int7} in read rows
	typedef struct packed {
		logic [2:0] kind;
		user_cfg_t  cfg;
		logic       ovl;
		logic [2:0] ctl;
		logic [3:0] n;         // request index, ntsc value or vsync count
		cfg_flags_t exp_flags;
	} row_t;

	logic           clk;
	logic           reset;
	logic           clk7_en_i;
	logic           sof_i;
	logic           cpu_reset_n_i;
	logic           cpu_rst_i;
	logic           ovl_i;
	logic           cpu_rd_i;
	logic           sel_rtc_i;
	logic           int7_i;
	logic           paula_sdo_i;
	logic           user_sdo_i;
	logic           vsync_n_i;
	logic           hblank_i;
	logic           led_n_i;
	logic           sys_reset_o;
	logic           rst_out_o;
	logic           cpu_reset_n_o;
	logic           ntsc_o;
	logic           sdo_o;
	logic           init_b_o;
	logic           pwr_led_o;
	logic [1:0]     en_cnt;
	logic [2:0]     ipl_n_i;
	logic [2:0]     cpu_ipl_n_o;
	rst_req_t       rst_req_i;
	user_cfg_t      user_cfg_i;
	user_cfg_t      user_cfg_o;
	user_cfg_t      cur_cfg;
	cfg_flags_t     cfg_flags_o;
	cpu_addr_t      cpu_addr_i;
	rtc_t           rtc_i;
	cpu_rd_src_t    cpu_src_i;
	custom_rd_src_t custom_src_i;
	data_word_t     cpu_data_o;
	data_word_t     custom_data_o;
	row_t           table_q [NROWS];
	logic           exp_ntsc;   // reference model state
	logic           exp_init;
	int             err_flags;
	int             err_cfg;
	int             err_word;
	int             err_ipl;
	int             err_bit;

	tb_clock_gen clkgen0 (.clk(clk), .reset(reset));

	minimig_glue dut0 (.*);

	// 7 MHz enable on every fourth clock
	always @(posedge clk) begin
		en_cnt    <= en_cnt + 2'd1;
		clk7_en_i <= (en_cnt == 2'd3);
	end

	// ------------------------------
	// compare tasks
	// ------------------------------
	task automatic check_flags(input string name, input cfg_flags_t exp, input cfg_flags_t act);
		if (act !== exp) begin
			err_flags++;
			$display("Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_cfg(input string name, input user_cfg_t exp, input user_cfg_t act);
		if (act !== exp) begin
			err_cfg++;
			$display("Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_word(input string name, input data_word_t exp, input data_word_t act);
		if (act !== exp) begin
			err_word++;
			$display("Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_ipl(input string name, input logic [2:0] exp, input logic [2:0] act);
		if (act !== exp) begin
			err_ipl++;
			$display("Error at %0t ns: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			err_bit++;
			$display("Error at %0t ns: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	// ------------------------------
	// reference and table helpers
	// ------------------------------
	function automatic cfg_flags_t ref_flags(input user_cfg_t c, input logic ovl);
		cfg_flags_t f;
		f.turbochipram = c.chipset.aga && !ovl && c.cpu.fast_chip && (c.mem.chip_size == 2'b11);
		f.turbokick    = !ovl && c.cpu.fast_kick && c.chipset.aga;
		f.aga          = c.chipset.aga;
		f.ecs          = c.chipset.ecs || c.chipset.aga;
		f.a1k          = c.chipset.a1k;
		f.slow_config  = c.mem.slow_size;
		return f;
	endfunction

	function automatic user_cfg_t make_cfg(input logic aga, input logic ecs, input logic a1k,
			input logic fchip, input logic fkick, input logic [1:0] chip, input logic [1:0] slow);
		user_cfg_t c;
		c = '0;
		c.mem.chip_size   = chip;
		c.mem.slow_size   = slow;
		c.mem.fast_size   = 2'd1;
		c.floppy          = 4'h5;   // filler not decoded here
		c.chipset.aga     = aga;
		c.chipset.ecs     = ecs;
		c.chipset.a1k     = a1k;
		c.ide             = 3'b101;
		c.cpu.fast_chip   = fchip;
		c.cpu.fast_kick   = fkick;
		return c;
	endfunction

	function automatic row_t make_row(input logic [2:0] kind, input user_cfg_t c, input logic ovl,
			input logic [2:0] ctl, input logic [3:0] n);
		row_t r;
		r.kind      = kind;
		r.cfg       = c;
		r.ovl       = ovl;
		r.ctl       = ctl;
		r.n         = n;
		r.exp_flags = ref_flags(c, ovl);
		return r;
	endfunction

	task automatic wait_en(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(posedge clk);
			if (clk7_en_i) seen++;   // value the DUT sampled on this edge
		end
	endtask

	task automatic pulse_sof();
		@(posedge clk);
		sof_i <= 1'b1;
		wait_en(1);
		sof_i <= 1'b0;
	endtask

	// counts frames out of reset once the requests are low
	task automatic release_seq();
		wait_en(2);   // hold to count
		for (int f = 1; f <= RESET_FRAMES; f++) begin
			pulse_sof();
			if (f < RESET_FRAMES) begin
				@(negedge clk);
				check_bit("sys_reset_o mid count", 1'b1, sys_reset_o);
			end
		end
		exp_ntsc = cur_cfg.chipset.ntsc;   // latched while in reset
		exp_init = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_bit("sys_reset_o released", 1'b0, sys_reset_o);
		check_bit("cpu_reset_n_o released", 1'b1, cpu_reset_n_o);
	endtask

	// ------------------------------
	// row tasks
	// ------------------------------
	task automatic run_reset(input row_t r);
		@(posedge clk);
		rst_req_i <= rst_req_t'(4'b0001 << r.n);
		wait_en(2);
		@(negedge clk);
		check_bit("sys_reset_o held", 1'b1, sys_reset_o);
		check_bit("rst_out_o held", 1'b1, rst_out_o);
		check_bit("cpu_reset_n_o held", 1'b0, cpu_reset_n_o);
		@(posedge clk);
		rst_req_i <= '0;
		release_seq();
		// reset instruction from the core held across an enable
		@(posedge clk);
		cpu_reset_n_i <= 1'b0;
		wait_en(1);
		@(negedge clk);
		check_bit("rst_out_o cpu reset", 1'b1, rst_out_o);
		check_bit("cpu_reset_n_o cpu reset", 1'b1, cpu_reset_n_o);
		check_bit("sys_reset_o cpu reset", 1'b0, sys_reset_o);
		// host cpu reset on its own
		@(posedge clk);
		cpu_reset_n_i <= 1'b1;
		cpu_rst_i     <= 1'b1;
		@(negedge clk);
		check_bit("cpu_reset_n_o cpu_rst", 1'b0, cpu_reset_n_o);
		check_bit("rst_out_o cpu_rst", 1'b0, rst_out_o);
		@(posedge clk);
		cpu_rst_i <= 1'b0;
		exp_ntsc = cur_cfg.chipset.ntsc;
		exp_init = 1'b0;
	endtask

	task automatic run_read(input row_t r);
		data_word_t exp_cpu;
		data_word_t exp_cus;
		data_word_t src_mask;
		// low nibble cleared so the rtc nibble shows on its own
		src_mask = (r.ctl[2] || r.ctl[1]) ? 16'hfff0 : 16'hffff;
		@(posedge clk);
		cpu_src_i    <= {data_word_t'($urandom) & src_mask, data_word_t'($urandom) & src_mask,
			data_word_t'($urandom) & src_mask, data_word_t'($urandom) & src_mask,
			data_word_t'($urandom) & src_mask};
		custom_src_i <= {data_word_t'($urandom), data_word_t'($urandom),
			data_word_t'($urandom), data_word_t'($urandom)};
		rtc_i        <= {$urandom, $urandom};
		cpu_addr_i   <= cpu_addr_t'($urandom);
		ipl_n_i      <= 3'($urandom);
		paula_sdo_i  <= 1'($urandom);
		user_sdo_i   <= 1'($urandom);
		{sel_rtc_i, cpu_rd_i, int7_i} <= r.ctl;
		@(negedge clk);
		exp_cpu = cpu_src_i.gary | cpu_src_i.cia | cpu_src_i.gayle | cpu_src_i.cart
			| cpu_src_i.autoconfig;
		if (r.ctl[2] && r.ctl[1])
			exp_cpu = exp_cpu | data_word_t'(rtc_i[4 * int'(cpu_addr_i[5:2]) +: 4]);
		exp_cus = custom_src_i.agnus | custom_src_i.paula | custom_src_i.denise
			| custom_src_i.userio;
		check_word("cpu_data_o", exp_cpu, cpu_data_o);
		check_word("custom_data_o", exp_cus, custom_data_o);
		check_bit("sdo_o", paula_sdo_i | user_sdo_i, sdo_o);
		check_ipl("cpu_ipl_n_o", r.ctl[0] ? 3'b000 : ipl_n_i, cpu_ipl_n_o);
	endtask

	task automatic run_ntsc(input row_t r);
		user_cfg_t c;
		c = cur_cfg;
		c.chipset.ntsc = r.n[0];
		@(posedge clk);
		user_cfg_i <= c;
		cur_cfg = c;
		wait_en(3);
		@(negedge clk);
		check_bit("ntsc_o outside reset", exp_ntsc, ntsc_o);   // no change while running
		@(posedge clk);
		rst_req_i <= 4'b0100;   // menu reset
		wait_en(2);
		rst_req_i <= '0;
		release_seq();
		check_bit("ntsc_o after reset", r.n[0], ntsc_o);
	endtask

	task automatic run_vsync(input row_t r);
		for (int i = 0; i < int'(r.n); i++) begin
			@(posedge clk);
			vsync_n_i <= 1'b0;
			wait_en(2);
			vsync_n_i <= 1'b1;
			wait_en(2);
		end
		if (r.n[0]) exp_init = ~exp_init;
		@(negedge clk);
		check_bit("init_b_o", exp_init, init_b_o);
		for (int k = 0; k < 4; k++) begin
			@(posedge clk);
			{led_n_i, hblank_i} <= 2'(k);
			@(negedge clk);
			check_bit("pwr_led_o", !(led_n_i && !hblank_i), pwr_led_o);
		end
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		void'($urandom(32'hd198));
		en_cnt        = 2'd0;
		clk7_en_i     = 1'b0;
		sof_i         = 1'b0;
		rst_req_i     = '0;
		cpu_reset_n_i = 1'b1;
		cpu_rst_i     = 1'b0;
		user_cfg_i    = '0;
		cur_cfg       = '0;
		ovl_i         = 1'b0;
		cpu_addr_i    = '0;
		cpu_rd_i      = 1'b0;
		sel_rtc_i     = 1'b0;
		rtc_i         = '0;
		cpu_src_i     = '0;
		custom_src_i  = '0;
		int7_i        = 1'b0;
		ipl_n_i       = 3'b111;
		paula_sdo_i   = 1'b0;
		user_sdo_i    = 1'b0;
		vsync_n_i     = 1'b1;
		hblank_i      = 1'b0;
		led_n_i       = 1'b0;
		exp_ntsc      = NTSC_DEFAULT;
		exp_init      = 1'b0;
		err_flags     = 0;
		err_cfg       = 0;
		err_word      = 0;
		err_ipl       = 0;
		err_bit       = 0;

		table_q[0]  = make_row(K_CONFIG, make_cfg(1, 0, 0, 1, 0, 2'd3, 2'd0), 0, 3'b000, 0);
		table_q[1]  = make_row(K_CONFIG, make_cfg(1, 0, 0, 1, 1, 2'd3, 2'd0), 1, 3'b000, 0);
		table_q[2]  = make_row(K_CONFIG, make_cfg(1, 0, 0, 0, 1, 2'd3, 2'd3), 0, 3'b000, 0);
		table_q[3]  = make_row(K_CONFIG, make_cfg(0, 1, 0, 1, 1, 2'd3, 2'd0), 0, 3'b000, 0);
		table_q[4]  = make_row(K_CONFIG, make_cfg(0, 0, 1, 0, 0, 2'd0, 2'd2), 0, 3'b000, 0);
		table_q[5]  = make_row(K_CONFIG, make_cfg(1, 0, 0, 1, 1, 2'd2, 2'd1), 0, 3'b000, 0);
		table_q[6]  = make_row(K_READ, '0, 0, 3'b110, 0);
		table_q[7]  = make_row(K_READ, '0, 0, 3'b100, 0);
		table_q[8]  = make_row(K_READ, '0, 0, 3'b010, 0);
		table_q[9]  = make_row(K_READ, '0, 0, 3'b111, 0);
		table_q[10] = make_row(K_READ, '0, 0, 3'b000, 0);
		table_q[11] = make_row(K_READ, '0, 0, 3'b011, 0);
		for (int i = 0; i < 4; i++)
			table_q[12 + i] = make_row(K_RESET, '0, 0, 3'b000, 4'(i));
		table_q[16] = make_row(K_NTSC, '0, 0, 3'b000, 4'd1);
		table_q[17] = make_row(K_NTSC, '0, 0, 3'b000, 4'd0);
		table_q[18] = make_row(K_VSYNC, '0, 0, 3'b000, 4'd3);
		table_q[19] = make_row(K_VSYNC, '0, 0, 3'b000, 4'd2);

		while (reset !== 1'b0) @(posedge clk);
		release_seq();   // power-up frames

		foreach (table_q[i]) begin
			case (table_q[i].kind)
				K_CONFIG: begin
					@(posedge clk);
					user_cfg_i <= table_q[i].cfg;
					ovl_i      <= table_q[i].ovl;
					cur_cfg = table_q[i].cfg;
					repeat (2) @(posedge clk);
					@(negedge clk);
					check_flags("cfg_flags_o", table_q[i].exp_flags, cfg_flags_o);
					check_cfg("user_cfg_o", table_q[i].cfg, user_cfg_o);
				end
				K_READ:  run_read(table_q[i]);
				K_RESET: run_reset(table_q[i]);
				K_NTSC:  run_ntsc(table_q[i]);
				default: run_vsync(table_q[i]);
			endcase
		end

		$display("errors: flags %0d cfg %0d word %0d ipl %0d bit %0d", err_flags, err_cfg,
			err_word, err_ipl, err_bit);
		if (err_flags + err_cfg + err_word + err_ipl + err_bit == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// watchdog sized from the table length
	initial begin
		#(NROWS * 400 * 4);
		$display("timeout: test table did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
